// File: adc_sample_decode.sv
`timescale 1ns/1ns
`include "pulse_capture_defs.svh"

module adc_sample_decode
    import pulse_capture_pkg::*;
(
    input  logic                  ADA_DCO,
    input  logic                  hps_fpga_reset_n,
    input  logic [`ADC_WIDTH-1:0] ada_d,      // channel a raw code
    input  logic [`ADC_WIDTH-1:0] adb_d,      // channel b raw code
    output sample_info_t          info_a,
    output sample_info_t          info_b
);

    logic [`ADC_WIDTH-1:0] raw_a;   // input capture stage
    logic [`ADC_WIDTH-1:0] raw_b;

    // threshold test and offset subtraction for one code
    function automatic sample_info_t decode_sample(input logic [`ADC_WIDTH-1:0] raw);
        sample_info_t        res;
        logic [`ADC_WIDTH:0] diff;  // one extra bit for full scale
        diff     = (`ADC_WIDTH+1)'(`FULL_SCALE) - {1'b0, raw};
        res.neg  = (raw >= `ADC_WIDTH'(`NEG_THRESHOLD));
        res.mag  = res.neg ? diff[`MAG_WIDTH-1:0] : '0;    // positive side reads as zero
        return res;
    endfunction

    // two register stages, raw then decoded
    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            raw_a  <= '0;
            raw_b  <= '0;
            info_a <= '0;
            info_b <= '0;
        end
        else
        begin
            raw_a  <= ada_d;
            raw_b  <= adb_d;
            info_a <= decode_sample(raw_a);     // k+1 for a code taken at k
            info_b <= decode_sample(raw_b);
        end
    end

endmodule

// File: list.f
+incdir+.
pulse_capture_pkg.sv
adc_sample_decode.sv
pulse_peak_tail.sv
readout_snapshot.sv
pulse_capture_top.sv
tb_pulse_capture.sv

// File: pulse_capture_defs.svh
`ifndef PULSE_CAPTURE_DEFS_SVH
`define PULSE_CAPTURE_DEFS_SVH

//////////////////////////////
// adc sample format
//////////////////////////////

`define ADC_WIDTH 14        // raw bus width per channel

// offset binary, upper half of the code range is negative
`define NEG_THRESHOLD 8192

`define FULL_SCALE 16384    // magnitude = full scale minus raw code

`define MAG_WIDTH 14        // holds 8192 at most

//////////////////////////////
// time base
//////////////////////////////

`define TIME_WIDTH 26       // free running stamp counter

`endif

// File: pulse_capture_pkg.sv
`include "pulse_capture_defs.svh"

package pulse_capture_pkg;

    // one decoded sample
    typedef struct packed
    {
        logic                   neg;    // raw code at or above threshold
        logic [`MAG_WIDTH-1:0]  mag;    // zero unless neg
    } sample_info_t;

    // result of one finished negative run
    typedef struct packed
    {
        logic [`MAG_WIDTH-1:0]  peak;   // largest magnitude in the run
        logic [`MAG_WIDTH-1:0]  tail;   // magnitude of the last sample
    } pulse_event_t;

    // host visible snapshot
    typedef struct packed
    {
        logic [`MAG_WIDTH-1:0]  peak_a;
        logic [`MAG_WIDTH-1:0]  tail_a;
        logic [`MAG_WIDTH-1:0]  peak_b;
        logic [`MAG_WIDTH-1:0]  tail_b;
        logic [`TIME_WIDTH-1:0] time_stamp; // counter at latest event, either channel
    } readout_t;

endpackage

// File: pulse_capture_top.sv
`timescale 1ns/1ns
`include "pulse_capture_defs.svh"

module pulse_capture_top
    import pulse_capture_pkg::*;
(
    input  logic                  ADA_DCO,            // sample clock, both channels
    input  logic                  hps_fpga_reset_n,
    input  logic [`ADC_WIDTH-1:0] ada_d,
    input  logic [`ADC_WIDTH-1:0] adb_d,
    input  logic                  read_req,
    output logic                  read_ack,
    output readout_t              read_data
);

    sample_info_t info_a;           // decoded channel a
    sample_info_t info_b;
    logic         event_valid_a;
    logic         event_valid_b;
    pulse_event_t event_data_a;
    pulse_event_t event_data_b;

    //////////////////////////////
    // sample path
    //////////////////////////////

    adc_sample_decode decode (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .info_a           (info_a),
        .info_b           (info_b)
    );

    pulse_peak_tail execute_a (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .info             (info_a),
        .event_valid      (event_valid_a),
        .event_data       (event_data_a)
    );

    pulse_peak_tail execute_b (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .info             (info_b),
        .event_valid      (event_valid_b),
        .event_data       (event_data_b)
    );

    // store, time stamp and host side
    readout_snapshot result (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .event_valid_a    (event_valid_a),
        .event_data_a     (event_data_a),
        .event_valid_b    (event_valid_b),
        .event_data_b     (event_data_b),
        .read_req         (read_req),
        .read_ack         (read_ack),
        .read_data        (read_data)
    );

endmodule

// File: pulse_peak_tail.sv
`timescale 1ns/1ns
`include "pulse_capture_defs.svh"

module pulse_peak_tail
    import pulse_capture_pkg::*;
(
    input  logic         ADA_DCO,
    input  logic         hps_fpga_reset_n,
    input  sample_info_t info,          // decoded sample, one per edge
    output logic         event_valid,   // single cycle, run just ended
    output pulse_event_t event_data     // peak and tail of that run
);

    logic                  in_run;      // previous sample was negative
    logic [`MAG_WIDTH-1:0] run_max;     // running peak
    logic [`MAG_WIDTH-1:0] run_last;    // latest magnitude of the run
    logic                  run_end;

    // first non negative sample after a run closes it
    assign run_end = in_run && !info.neg;

    //////////////////////////////
    // run tracking
    //////////////////////////////

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            in_run      <= 1'b0;
            run_max     <= '0;
            run_last    <= '0;
            event_valid <= 1'b0;
        end
        else
        begin
            event_valid <= run_end;     // high for one cycle only
            if (info.neg)
            begin
                in_run   <= 1'b1;
                run_last <= info.mag;
                if (info.mag > run_max)
                begin
                    run_max <= info.mag;
                end
            end
            else
            begin
                // run closed or idle, start clean
                in_run   <= 1'b0;
                run_max  <= '0;
                run_last <= '0;
            end
        end
    end

    // result holds until the next run ends
    always_ff @(posedge ADA_DCO)
    begin
        if (run_end)
        begin
            event_data.peak <= run_max;
            event_data.tail <= run_last;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // a run needs at least one negative sample, so events are spaced
    a_event_single : assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        event_valid |=> !event_valid)
        else $error("event_valid high on two cycles in a row");

endmodule

// File: readout_snapshot.sv
`timescale 1ns/1ns
`include "pulse_capture_defs.svh"

module readout_snapshot
    import pulse_capture_pkg::*;
(
    input  logic         ADA_DCO,
    input  logic         hps_fpga_reset_n,
    input  logic         event_valid_a,
    input  pulse_event_t event_data_a,
    input  logic         event_valid_b,
    input  pulse_event_t event_data_b,
    input  logic         read_req,      // host holds high until ack
    output logic         read_ack,
    output readout_t     read_data      // frozen while ack is high
);

    logic [`TIME_WIDTH-1:0] time_cnt;   // free running
    readout_t               store;      // latest events, always live
    logic                   req_q;      // registered host request

    //////////////////////////////
    // time base and event store
    //////////////////////////////

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            time_cnt <= '0;
            store    <= '0;
        end
        else
        begin
            time_cnt <= time_cnt + 1'b1;    // wraps after 2^26 cycles
            if (event_valid_a)
            begin
                store.peak_a <= event_data_a.peak;
                store.tail_a <= event_data_a.tail;
            end
            if (event_valid_b)
            begin
                store.peak_b <= event_data_b.peak;
                store.tail_b <= event_data_b.tail;
            end
            // stamp shared by both channels
            if (event_valid_a || event_valid_b)
            begin
                store.time_stamp <= time_cnt;
            end
        end
    end

    //////////////////////////////
    // host req/ack
    //////////////////////////////

    always_ff @(posedge ADA_DCO or negedge hps_fpga_reset_n)
    begin
        if (!hps_fpga_reset_n)
        begin
            req_q     <= 1'b0;
            read_ack  <= 1'b0;
            read_data <= '0;
        end
        else
        begin
            req_q <= read_req;
            if (req_q && !read_ack)
            begin
                read_ack  <= 1'b1;      // new request, take the snapshot
                read_data <= store;
            end
            else if (!req_q && read_ack)
            begin
                read_ack <= 1'b0;       // host released, close the cycle
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_ack_needs_req : assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        $rose(read_ack) |-> $past(read_req))
        else $error("read_ack rose without read_req");

    // events keep landing in store, the snapshot must not follow them
    a_data_frozen : assert property (@(posedge ADA_DCO) disable iff (!hps_fpga_reset_n)
        read_ack |=> $stable(read_data))
        else $error("read_data changed while read_ack high");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_pulse_capture -f list.f -o tb_pulse_capture

sim_out=$(./obj_dir/tb_pulse_capture || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb_pulse_capture.sv
`timescale 1ns/1ns
`include "pulse_capture_defs.svh"

module tb_pulse_capture
    import pulse_capture_pkg::*;
;

    typedef logic [`ADC_WIDTH-1:0] raw_t;
    typedef logic [95:0]           word_t;  // wide enough for a whole readout

    localparam int ACK_TIMEOUT   = 20;      // cycles per handshake wait
    localparam int SETTLE_CYCLES = 8;       // pipeline is 3 deep, plenty

    logic                   ADA_DCO;
    logic                   hps_fpga_reset_n;
    raw_t                   ada_d;
    raw_t                   adb_d;
    logic                   read_req;
    logic                   read_ack;
    readout_t               read_data;

    integer                 seed;
    raw_t                   seq_a[$];       // samples to play, one pair per edge
    raw_t                   seq_b[$];
    pulse_event_t           ref_out[$];     // runs found by the reference
    readout_t               exp_store;      // model of the latest-event store
    bit                     exp_new;        // events since the last read
    readout_t               exp_q[$];       // one entry per read started
    bit                     mode_q[$];
    readout_t               held;           // snapshot at ack rise
    readout_t               last_data;
    logic [`TIME_WIDTH-1:0] prev_ts;
    logic                   ack_seen;

    pulse_capture_top DUT (
        .ADA_DCO          (ADA_DCO),
        .hps_fpga_reset_n (hps_fpga_reset_n),
        .ada_d            (ada_d),
        .adb_d            (adb_d),
        .read_req         (read_req),
        .read_ack         (read_ack),
        .read_data        (read_data)
    );

    always #4 ADA_DCO = ~ADA_DCO;   // 8 ns period

    //////////////////////////////
    // reporting
    //////////////////////////////

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual)
        begin
            $display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // offset binary decode, then peak/tail of every run closed by a positive sample
    function automatic int ref_runs(input raw_t seq[$]);
        int           r;
        int           mag;
        int           peak;
        int           tail;
        bit           in_run;
        pulse_event_t ev;
        ref_out.delete();
        in_run = 1'b0;
        peak   = 0;
        tail   = 0;
        for (int i = 0; i < seq.size(); i++)
        begin
            r = int'(seq[i]);
            if (r >= `NEG_THRESHOLD)
            begin
                mag    = `FULL_SCALE - r;
                in_run = 1'b1;
                tail   = mag;
                if (mag > peak)
                    peak = mag;
            end
            else if (in_run)
            begin
                ev.peak = `MAG_WIDTH'(peak);
                ev.tail = `MAG_WIDTH'(tail);
                ref_out.push_back(ev);
                in_run  = 1'b0;
                peak    = 0;
                tail    = 0;
            end
        end
        return ref_out.size();
    endfunction

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    task automatic add_pair(input raw_t a, input raw_t b);
        seq_a.push_back(a);
        seq_b.push_back(b);
    endtask

    // plays the queued pairs from the current falling edge, then models them
    task automatic play_sequence();
        int n;
        for (int i = 0; i < seq_a.size(); i++)
        begin
            ada_d = seq_a[i];
            adb_d = seq_b[i];
            @(negedge ADA_DCO);
        end
        ada_d = '0;     // idle low, non negative
        adb_d = '0;
        n = ref_runs(seq_a);
        if (n > 0)
        begin
            exp_store.peak_a = ref_out[n-1].peak;     // last finished run wins
            exp_store.tail_a = ref_out[n-1].tail;
            exp_new          = 1'b1;
        end
        n = ref_runs(seq_b);
        if (n > 0)
        begin
            exp_store.peak_b = ref_out[n-1].peak;
            exp_store.tail_b = ref_out[n-1].tail;
            exp_new          = 1'b1;
        end
        seq_a.delete();
        seq_b.delete();
        repeat (SETTLE_CYCLES) @(negedge ADA_DCO);
    endtask

    task automatic random_pairs(input int len);
        integer va;
        integer vb;
        for (int i = 0; i < len; i++)
        begin
            va = $random(seed);
            vb = $random(seed);
            add_pair(va[`ADC_WIDTH-1:0], vb[`ADC_WIDTH-1:0]);
        end
        add_pair(`ADC_WIDTH'(100), `ADC_WIDTH'(100));  // close any open run
    endtask

    // four phase read; inject plays a run on channel a while ack is high
    task automatic host_read(input bit inject);
        int waited;
        exp_q.push_back(exp_store);
        mode_q.push_back(exp_new);
        exp_new = 1'b0;
        read_req = 1'b1;
        waited   = 0;
        while (!read_ack)
        begin
            @(negedge ADA_DCO);
            waited++;
            if (waited > ACK_TIMEOUT)
            begin
                $display("timeout waiting for read_ack to rise after read_req");
                abort_run();
            end
        end
        if (inject)
        begin
            add_pair(`ADC_WIDTH'(9500), '0);
            add_pair(`ADC_WIDTH'(15000), '0);
            add_pair(`ADC_WIDTH'(200), '0);
            play_sequence();    // store moves, read_data must not
        end
        read_req = 1'b0;
        waited   = 0;
        while (read_ack)
        begin
            @(negedge ADA_DCO);
            waited++;
            if (waited > ACK_TIMEOUT)
            begin
                $display("timeout waiting for read_ack to fall after read_req dropped");
                abort_run();
            end
        end
    endtask

    //////////////////////////////
    // compare process
    //////////////////////////////

    always @(negedge ADA_DCO)
    begin
        if (hps_fpga_reset_n)
        begin
            if (read_ack && !ack_seen)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("read_ack rose with no read pending");
                    abort_run();
                end
                held = exp_q.pop_front();
                check_value("read_data.peak_a", word_t'(held.peak_a), word_t'(read_data.peak_a));
                check_value("read_data.tail_a", word_t'(held.tail_a), word_t'(read_data.tail_a));
                check_value("read_data.peak_b", word_t'(held.peak_b), word_t'(read_data.peak_b));
                check_value("read_data.tail_b", word_t'(held.tail_b), word_t'(read_data.tail_b));
                if (mode_q.pop_front())
                begin
                    // fresh events, stamp must move forward
                    check_value("time_stamp nonzero", word_t'(1),
                                word_t'(read_data.time_stamp != '0));
                    check_value("time_stamp increase", word_t'(1),
                                word_t'(read_data.time_stamp > prev_ts));
                end
                else
                    check_value("read_data.time_stamp", word_t'(prev_ts),
                                word_t'(read_data.time_stamp));
                held      = read_data;
                last_data = read_data;
                prev_ts   = read_data.time_stamp;
            end
            else if (read_ack)
                check_value("read_data", word_t'(held), word_t'(read_data));  // frozen
            ack_seen = read_ack;
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        seed             = 17;
        ADA_DCO          = 1'b0;
        hps_fpga_reset_n = 1'b0;
        ada_d            = '0;
        adb_d            = '0;
        read_req         = 1'b0;
        exp_store        = '0;
        exp_new          = 1'b0;
        prev_ts          = '0;
        ack_seen         = 1'b0;
        repeat (4) @(posedge ADA_DCO);
        @(negedge ADA_DCO);
        hps_fpga_reset_n = 1'b1;
        @(negedge ADA_DCO);
        check_value("read_ack", '0, word_t'(read_ack));

        host_read(1'b0);    // empty store
        check_value("read_data", '0, word_t'(last_data));

        // single run on a, 16384 minus each code
        add_pair(`ADC_WIDTH'(9000), '0);
        add_pair(`ADC_WIDTH'(12000), '0);
        add_pair(`ADC_WIDTH'(10000), '0);
        add_pair(`ADC_WIDTH'(100), '0);
        play_sequence();
        host_read(1'b0);
        check_value("peak_a", word_t'(7384), word_t'(last_data.peak_a));
        check_value("tail_a", word_t'(6384), word_t'(last_data.tail_a));
        check_value("peak_b", '0, word_t'(last_data.peak_b));
        check_value("tail_b", '0, word_t'(last_data.tail_b));

        // threshold edges, 8192 negative and 8191 not
        add_pair(`ADC_WIDTH'(8192), `ADC_WIDTH'(8191));
        add_pair(`ADC_WIDTH'(8191), `ADC_WIDTH'(16383));
        add_pair(`ADC_WIDTH'(100), `ADC_WIDTH'(8191));
        play_sequence();
        host_read(1'b0);
        check_value("peak_a", word_t'(8192), word_t'(last_data.peak_a));
        check_value("tail_a", word_t'(8192), word_t'(last_data.tail_a));
        check_value("peak_b", word_t'(1), word_t'(last_data.peak_b));

        host_read(1'b1);    // events arrive under ack
        host_read(1'b0);
        check_value("peak_a", word_t'(6884), word_t'(last_data.peak_a));
        check_value("tail_a", word_t'(1384), word_t'(last_data.tail_a));

        for (int it = 0; it < 8; it++)
        begin
            random_pairs(24);
            play_sequence();
            host_read(it[0]);   // every other read gets injected events
        end
        host_read(1'b0);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
